/* dv/me_tb.sv */
`include "me_defs.svh"

module me_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import me_arith_pkg::*;

    localparam int OP_W           = `ME_OP_W;
    localparam int WORD_W         = `ME_WORD_W;
    localparam int NUM_W          = `ME_NUM_WORDS;
    localparam int RESULT_TIMEOUT = 20000;
    localparam logic [31:0] SEED  = 32'h0e2c_9fab;
    localparam operand_t MODULUS  = `ME_MODULUS;

    typedef logic [2*OP_W-1:0] dbl_t;

    logic        clk;
    logic        rst_n;
    logic        me_start;
    word_t       me_x;
    logic        me_x_valid;
    word_t       me_y;
    logic        me_y_valid;
    word_t       me_result;
    logic        me_valid;

    logic [31:0] rng;
    int          checks_done;

    me_top uut (
        .clk        (clk),
        .rst_n      (rst_n),
        .me_start   (me_start),
        .me_x       (me_x),
        .me_x_valid (me_x_valid),
        .me_y       (me_y),
        .me_y_valid (me_y_valid),
        .me_result  (me_result),
        .me_valid   (me_valid)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // --------------------
    // reference model
    // --------------------

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] v;
        v = s;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    function automatic operand_t rand_operand();
        logic [31:0] hi;
        rng = xorshift32(rng);
        hi  = rng;
        rng = xorshift32(rng);
        return {hi, rng};
    endfunction

    // full double-width product, then reduce
    function automatic operand_t mulmod(input operand_t a, input operand_t b);
        dbl_t prod;
        dbl_t rem;
        prod = dbl_t'(a) * dbl_t'(b);
        rem  = prod % dbl_t'(MODULUS);
        return rem[OP_W-1:0];
    endfunction

    // plain square-and-multiply, msb first over all exponent bits
    function automatic operand_t modexp_ref(input operand_t x, input operand_t y);
        operand_t base;
        operand_t acc;
        base = mulmod(x, 64'd1);
        acc  = 64'd1;
        for (int i = OP_W - 1; i >= 0; i--) begin
            acc = mulmod(acc, acc);
            if (y[i]) begin
                acc = mulmod(acc, base);
            end
        end
        return acc;
    endfunction

    // --------------------
    // drivers and monitor
    // --------------------

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic pulse_start();
        @(posedge clk);
        me_start <= 1'b1;
        @(posedge clk);
        me_start <= 1'b0;
    endtask

    // low word first, random idle cycles up to max_gap before each word
    task automatic send_words(input operand_t v, input bit to_y, input int max_gap);
        int    gap;
        word_t word;
        for (int w = 0; w < NUM_W; w++) begin
            rng  = xorshift32(rng);
            gap  = (max_gap == 0) ? 0 : int'(rng[2:0]) % (max_gap + 1);
            word = v[w*WORD_W +: WORD_W];
            repeat (gap) begin
                @(posedge clk);
                me_x_valid <= 1'b0;
                me_y_valid <= 1'b0;
            end
            @(posedge clk);
            if (to_y) begin
                me_y       <= word;
                me_y_valid <= 1'b1;
                me_x_valid <= 1'b0;
            end else begin
                me_x       <= word;
                me_x_valid <= 1'b1;
                me_y_valid <= 1'b0;
            end
        end
        @(posedge clk);
        me_x_valid <= 1'b0;
        me_y_valid <= 1'b0;
    endtask

    // outputs sampled on the falling edge
    task automatic collect_result(input operand_t expected, input string name);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!me_valid && waited < RESULT_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!me_valid) begin
            abort_run($sformatf("timed out waiting for the result of %s", name));
        end
        for (int w = 0; w < NUM_W; w++) begin
            assert (me_valid) else begin
                abort_run($sformatf("ERROR %0t: %s burst ended after %0d words",
                                    $time, name, w));
            end
            assert (me_result == expected[w*WORD_W +: WORD_W]) else begin
                abort_run($sformatf("ERROR %0t: %s word %0d got %h expected %h",
                                    $time, name, w, me_result,
                                    expected[w*WORD_W +: WORD_W]));
            end
            if (w < NUM_W - 1) begin
                @(negedge clk);
            end
        end
        @(negedge clk);
        assert (!me_valid) else begin
            abort_run($sformatf("ERROR %0t: %s burst longer than %0d words",
                                $time, name, NUM_W));
        end
        checks_done++;
    endtask

    task automatic run_case(input operand_t x, input operand_t y, input operand_t expected,
                            input int max_gap, input string name);
        send_words(y, 1'b1, 0);
        pulse_start();
        send_words(x, 1'b0, max_gap);
        collect_result(expected, name);
    endtask

    // --------------------
    // directed tests
    // --------------------

    task automatic idle_after_reset();
        // also covers the R^2 startup delay
        repeat (300) begin
            @(negedge clk);
            assert (!me_valid) else begin
                abort_run($sformatf("ERROR %0t: me_valid high without a start", $time));
            end
        end
    endtask

    task automatic small_fixed_case();
        run_case(64'd3, 64'd5, 64'd243, 0, "3^5");
    endtask

    task automatic edge_exponents();
        operand_t big_x;
        big_x = 64'hffff_ffff_ffff_fff0;
        run_case(64'd12345, 64'd0, 64'd1, 1, "zero exponent");
        // m > 2^63, so one subtraction reduces any 64-bit x
        run_case(big_x, 64'd1, big_x - MODULUS, 1, "x above m");
    endtask

    task automatic random_runs();
        operand_t x;
        operand_t y;
        for (int n = 0; n < 6; n++) begin
            x = rand_operand();
            y = rand_operand();
            run_case(x, y, modexp_ref(x, y), 5, $sformatf("random run %0d", n));
        end
    endtask

    task automatic y_persists_across_runs();
        operand_t x1;
        operand_t x2;
        operand_t y;
        x1 = rand_operand();
        x2 = rand_operand();
        y  = rand_operand();
        run_case(x1, y, modexp_ref(x1, y), 3, "first run with y");
        // no y words this time
        pulse_start();
        send_words(x2, 1'b0, 3);
        collect_result(modexp_ref(x2, y), "second run reusing y");
    endtask

    initial begin
        rng         = SEED;
        checks_done = 0;
        rst_n      <= 1'b0;
        me_start   <= 1'b0;
        me_x       <= '0;
        me_x_valid <= 1'b0;
        me_y       <= '0;
        me_y_valid <= 1'b0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;

        idle_after_reset();
        small_fixed_case();
        edge_exponents();
        random_runs();
        y_persists_across_runs();

        if (checks_done > 0) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            abort_run("no result was checked");
        end
    end

endmodule

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module me_tb -f tb.f -o me_sim

./obj_dir/me_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation failed" sim.log; then
    exit 1
fi
if ! grep -q "Simulation completed successfully" sim.log; then
    exit 1
fi

/* src/exp_ctrl.sv */
`include "me_defs.svh"

module exp_ctrl (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   me_start,
    input  logic                   x_full,
    input  logic                   r2_ready,
    input  me_arith_pkg::operand_t x_value,
    input  me_arith_pkg::operand_t y_value,
    input  me_arith_pkg::operand_t r2,
    output logic                   x_clear,
    output logic                   mul_start,
    output me_arith_pkg::mul_req_t mul_req,
    input  logic                   mul_done,
    input  me_arith_pkg::operand_t product,
    output me_arith_pkg::word_t    me_result,
    output logic                   me_valid
);
    import me_arith_pkg::*;
    import me_ctrl_pkg::*;

    localparam int BIT_W = $clog2(`ME_OP_W);
    localparam int OUT_W = $clog2(`ME_NUM_WORDS);
    localparam logic [BIT_W-1:0] LAST_BIT = BIT_W'(`ME_OP_W - 1);
    localparam logic [OUT_W-1:0] LAST_WORD = OUT_W'(`ME_NUM_WORDS - 1);
    localparam operand_t ONE = operand_t'(1);

    exp_phase_t       phase;
    exp_phase_t       phase_next;
    logic [BIT_W-1:0] bit_cnt;
    logic [OUT_W-1:0] out_cnt;
    logic             load_go;
    logic             issue;
    logic             next_bit;
    mul_req_t         req_next;
    operand_t         x_mont;
    operand_t         y_sh;
    operand_t         out_sh;

    // start is only taken while idle
    assign x_clear = (phase == PH_IDLE) && me_start;

    // --------------------
    // next phase and request
    // --------------------

    // product is the running acc whenever mul_done is high
    always_comb begin
        phase_next = phase;
        load_go    = 1'b0;
        issue      = 1'b0;
        next_bit   = 1'b0;
        req_next   = '0;
        case (phase)
            PH_IDLE: begin
                if (me_start) begin
                    phase_next = PH_LOAD;
                end
            end
            PH_LOAD: begin
                // also waits here if r2 is not there yet
                if (x_full && r2_ready) begin
                    load_go    = 1'b1;
                    issue      = 1'b1;
                    req_next   = '{a: x_value, b: r2};
                    phase_next = PH_TO_MONT;
                end
            end
            PH_TO_MONT: begin
                // mont(1, R^2) gives R mod m
                if (mul_done) begin
                    issue      = 1'b1;
                    req_next   = '{a: ONE, b: r2};
                    phase_next = PH_INIT_ACC;
                end
            end
            PH_INIT_ACC: begin
                if (mul_done) begin
                    issue      = 1'b1;
                    req_next   = '{a: product, b: product};
                    phase_next = PH_SQUARE;
                end
            end
            PH_SQUARE, PH_MULT: begin
                if (mul_done) begin
                    issue = 1'b1;
                    if (phase == PH_SQUARE && y_sh[`ME_OP_W-1]) begin
                        req_next   = '{a: product, b: x_mont};
                        phase_next = PH_MULT;
                    end else if (bit_cnt == LAST_BIT) begin
                        req_next   = '{a: product, b: ONE};
                        phase_next = PH_FROM_MONT;
                    end else begin
                        next_bit   = 1'b1;
                        req_next   = '{a: product, b: product};
                        phase_next = PH_SQUARE;
                    end
                end
            end
            PH_FROM_MONT: begin
                if (mul_done) begin
                    phase_next = PH_OUTPUT;
                end
            end
            PH_OUTPUT: begin
                if (out_cnt == LAST_WORD) begin
                    phase_next = PH_IDLE;
                end
            end
            default: begin
                phase_next = PH_IDLE;
            end
        endcase
    end

    // --------------------
    // state
    // --------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase     <= PH_IDLE;
            mul_start <= 1'b0;
            me_valid  <= 1'b0;
            bit_cnt   <= '0;
            out_cnt   <= '0;
        end else begin
            phase     <= phase_next;
            mul_start <= issue;
            me_valid  <= (phase_next == PH_OUTPUT);
            if (load_go) begin
                bit_cnt <= '0;
            end else if (next_bit) begin
                bit_cnt <= bit_cnt + 1'b1;
            end
            out_cnt <= (phase == PH_OUTPUT) ? out_cnt + 1'b1 : '0;
        end
    end

    // exponent msb first, result low word first
    always_ff @(posedge clk) begin
        if (issue) begin
            mul_req <= req_next;
        end
        if (phase == PH_TO_MONT && mul_done) begin
            x_mont <= product;
        end
        if (load_go) begin
            y_sh <= y_value;
        end else if (next_bit) begin
            y_sh <= y_sh << 1;
        end
        if (phase == PH_FROM_MONT && mul_done) begin
            out_sh <= product;
        end else if (phase == PH_OUTPUT) begin
            out_sh <= out_sh >> `ME_WORD_W;
        end
    end

    assign me_result = out_sh[`ME_WORD_W-1:0];

    // one unbroken burst per run
    a_valid_burst: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(me_valid) |-> me_valid [*`ME_NUM_WORDS] ##1 !me_valid);

endmodule

/* src/me_arith_pkg.sv */
`include "me_defs.svh"

package me_arith_pkg;

    // --------------------
    // datapath types
    // --------------------

    // one word as it crosses the top-level ports
    typedef logic [`ME_WORD_W-1:0] word_t;

    // full operand or residue mod m
    typedef logic [`ME_OP_W-1:0] operand_t;

    // montgomery accumulator
    // holds values below 2m plus one addition of b and m
    typedef logic [`ME_OP_W+1:0] wide_t;

    // operands of one montgomery product, a is scanned bit by bit
    typedef struct packed {
        operand_t a;
        operand_t b;
    } mul_req_t;

endpackage

/* src/me_ctrl_pkg.sv */
package me_ctrl_pkg;

    // phases of the square-and-multiply sequencer
    typedef enum logic [2:0] {
        PH_IDLE      = 3'd0,
        PH_LOAD      = 3'd1,
        // x into montgomery form
        PH_TO_MONT   = 3'd2,
        // acc = R mod m
        PH_INIT_ACC  = 3'd3,
        PH_SQUARE    = 3'd4,
        PH_MULT      = 3'd5,
        // back to normal residue
        PH_FROM_MONT = 3'd6,
        PH_OUTPUT    = 3'd7
    } exp_phase_t;

endpackage

/* src/me_defs.svh */
`ifndef ME_DEFS_SVH
`define ME_DEFS_SVH

// --------------------
// operand geometry
// --------------------

// one transfer word on the x, y and result ports
`define ME_WORD_W     16

// words per operand, low word first on the wire
`define ME_NUM_WORDS  4

// full operand width
`define ME_OP_W       (`ME_WORD_W * `ME_NUM_WORDS)

// --------------------
// modulus
// --------------------

// fixed odd modulus, top bit set so R = 2^ME_OP_W > m
`define ME_MODULUS    64'hc6a4_a793_5bd1_e995

`endif

/* src/me_top.sv */
module me_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                me_start,
    input  me_arith_pkg::word_t me_x,
    input  logic                me_x_valid,
    input  me_arith_pkg::word_t me_y,
    input  logic                me_y_valid,
    output me_arith_pkg::word_t me_result,
    output logic                me_valid
);
    import me_arith_pkg::*;

    logic     x_clear;
    logic     x_full;
    operand_t x_value;
    operand_t y_value;
    operand_t r2;
    logic     r2_ready;
    logic     mul_start;
    mul_req_t mul_req;
    logic     mul_done;
    operand_t product;

    // --------------------
    // operand capture
    // --------------------

    operand_collector u_x_col (
        .clk        (clk),
        .rst_n      (rst_n),
        .clear      (x_clear),
        .word_in    (me_x),
        .word_valid (me_x_valid),
        .value      (x_value),
        .full       (x_full)
    );

    // y keeps the last words ever received, never cleared
    operand_collector u_y_col (
        .clk        (clk),
        .rst_n      (rst_n),
        .clear      (1'b0),
        .word_in    (me_y),
        .word_valid (me_y_valid),
        .value      (y_value),
        .full       ()
    );

    // --------------------
    // arithmetic
    // --------------------

    r2_precompute u_r2 (
        .clk   (clk),
        .rst_n (rst_n),
        .r2    (r2),
        .ready (r2_ready)
    );

    mont_mul u_mul (
        .clk       (clk),
        .rst_n     (rst_n),
        .mul_start (mul_start),
        .req       (mul_req),
        .mul_done  (mul_done),
        .product   (product)
    );

    exp_ctrl u_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .me_start  (me_start),
        .x_full    (x_full),
        .r2_ready  (r2_ready),
        .x_value   (x_value),
        .y_value   (y_value),
        .r2        (r2),
        .x_clear   (x_clear),
        .mul_start (mul_start),
        .mul_req   (mul_req),
        .mul_done  (mul_done),
        .product   (product),
        .me_result (me_result),
        .me_valid  (me_valid)
    );

endmodule

/* src/mont_mul.sv */
`include "me_defs.svh"

module mont_mul (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   mul_start,
    input  me_arith_pkg::mul_req_t req,
    output logic                   mul_done,
    output me_arith_pkg::operand_t product
);
    import me_arith_pkg::*;

    localparam int CNT_W = $clog2(`ME_OP_W);
    localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(`ME_OP_W - 1);
    localparam wide_t MOD_W = wide_t'(`ME_MODULUS);

    logic             busy;
    logic [CNT_W-1:0] bit_cnt;
    operand_t         a_sh;
    operand_t         b_q;
    wide_t            acc;
    wide_t            sum;
    wide_t            sum_odd;
    wide_t            acc_next;
    wide_t            acc_red;

    // --------------------
    // radix-2 step
    // --------------------

    // acc < 2m stays true for any a as long as b < m
    always_comb begin
        sum      = acc + (a_sh[0] ? wide_t'(b_q) : '0);
        sum_odd  = sum[0] ? sum + MOD_W : sum;
        acc_next = sum_odd >> 1;
    end

    // final conditional subtraction, acc is held after the last step
    assign acc_red = acc - MOD_W;
    assign product = (acc >= MOD_W) ? acc_red[`ME_OP_W-1:0] : acc[`ME_OP_W-1:0];

    // --------------------
    // control
    // --------------------

    // load on start, then OP_W steps, done shows on the cycle after
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            bit_cnt  <= '0;
            mul_done <= 1'b0;
        end else begin
            mul_done <= 1'b0;
            if (mul_start) begin
                busy    <= 1'b1;
                bit_cnt <= '0;
            end else if (busy) begin
                bit_cnt <= bit_cnt + 1'b1;
                if (bit_cnt == LAST_BIT) begin
                    busy     <= 1'b0;
                    mul_done <= 1'b1;
                end
            end
        end
    end

    // operands and accumulator
    always_ff @(posedge clk) begin
        if (mul_start) begin
            acc  <= '0;
            a_sh <= req.a;
            b_q  <= req.b;
        end else if (busy) begin
            acc  <= acc_next;
            a_sh <= a_sh >> 1;
        end
    end

    // the sequencer must wait for mul_done before the next request
    a_no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
        mul_start |-> !busy);

    // acc bound held over all OP_W steps
    a_product_reduced: assert property (@(posedge clk) disable iff (!rst_n)
        mul_done |-> (product < `ME_MODULUS));

endmodule

/* src/operand_collector.sv */
`include "me_defs.svh"

module operand_collector (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   clear,
    input  me_arith_pkg::word_t    word_in,
    input  logic                   word_valid,
    output me_arith_pkg::operand_t value,
    output logic                   full
);
    import me_arith_pkg::*;

    localparam int CNT_W = $clog2(`ME_NUM_WORDS + 1);
    localparam logic [CNT_W-1:0] N_WORDS = CNT_W'(`ME_NUM_WORDS);

    logic [CNT_W-1:0] word_cnt;

    // --------------------
    // word count
    // --------------------

    // a word arriving together with clear counts as the first one
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            word_cnt <= '0;
        end else if (clear) begin
            word_cnt <= word_valid ? CNT_W'(1) : '0;
        end else if (word_valid && word_cnt != N_WORDS) begin
            word_cnt <= word_cnt + 1'b1;
        end
    end

    assign full = (word_cnt == N_WORDS);

    // --------------------
    // shift register
    // --------------------

    // new word enters at the top, so the first word ends up lowest
    always_ff @(posedge clk) begin
        if (word_valid) begin
            value <= {word_in, value[`ME_OP_W-1:`ME_WORD_W]};
        end
    end

endmodule

/* src/r2_precompute.sv */
`include "me_defs.svh"

module r2_precompute (
    input  logic                   clk,
    input  logic                   rst_n,
    output me_arith_pkg::operand_t r2,
    output logic                   ready
);
    import me_arith_pkg::*;

    localparam int CNT_W = $clog2(2 * `ME_OP_W + 1);
    localparam logic [CNT_W-1:0] N_DBL = CNT_W'(2 * `ME_OP_W);
    localparam logic [`ME_OP_W:0] MOD_X = {1'b0, `ME_MODULUS};

    logic [CNT_W-1:0]  dbl_cnt;
    operand_t          val;
    logic [`ME_OP_W:0] dbl;
    logic [`ME_OP_W:0] dbl_red;

    // --------------------
    // doubling step
    // --------------------

    // val < m, so 2*val < 2m and one subtraction is enough
    assign dbl     = {val, 1'b0};
    assign dbl_red = dbl - MOD_X;

    // 2^(2*OP_W) mod m, one doubling per cycle from 1
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            val     <= operand_t'(1);
            dbl_cnt <= '0;
            ready   <= 1'b0;
        end else if (dbl_cnt != N_DBL) begin
            val     <= (dbl >= MOD_X) ? dbl_red[`ME_OP_W-1:0] : dbl[`ME_OP_W-1:0];
            dbl_cnt <= dbl_cnt + 1'b1;
        end else begin
            // hold result from here on
            ready <= 1'b1;
        end
    end

    assign r2 = val;

    // constant must already be reduced when the sequencer picks it up
    a_r2_reduced: assert property (@(posedge clk) disable iff (!rst_n)
        ready |-> (r2 < `ME_MODULUS));

endmodule

/* tb.f */
+incdir+src
src/me_arith_pkg.sv
src/me_ctrl_pkg.sv
src/operand_collector.sv
src/r2_precompute.sv
src/mont_mul.sv
src/exp_ctrl.sv
src/me_top.sv
dv/me_tb.sv
